// ==== alu_pkg.sv ====
package alu_pkg;

    localparam int word_width = 16;            // data path width
    localparam int cmd_width  = 4;             // one nibble per command
    localparam int sel_width  = 3;             // selector bits decoded from the command

    typedef logic [word_width-1:0] word_t;     // one data word

    typedef enum logic [cmd_width-1:0] {
        op_transfer   = 4'd0,                  // in1
        op_inc        = 4'd1,                  // in1 + 1
        op_add        = 4'd2,                  // in1 + in2
        op_add_plus1  = 4'd3,                  // in1 + in2 + 1
        op_sub_minus1 = 4'd4,                  // in1 + ~in2
        op_sub        = 4'd5,                  // in1 + ~in2 + 1
        op_dec        = 4'd6,                  // in1 + all ones
        op_transfer2  = 4'd7,                  // in1 + all ones + 1
        op_and        = 4'd8,
        op_or         = 4'd9,
        op_xor        = 4'd10,
        op_not        = 4'd11                  // ~in1
    } alu_op_t;

    // bit 0 passes in2 to the adder and bit 1 passes ~in2, both set gives all ones
    // bit 2 picks the logic block, whose four-way choice reuses bits 1..0
    function automatic logic [sel_width-1:0] op_sel(alu_op_t cmd);
        logic [sel_width-1:0] sel;
        sel[0] = (cmd == op_add) || (cmd == op_add_plus1) || (cmd == op_dec) ||
                 (cmd == op_transfer2) || (cmd == op_or) || (cmd == op_not);
        sel[1] = cmd[2] | (cmd[3] & cmd[1]);   // sub family, dec, xor and not
        sel[2] = cmd[3];                       // upper four commands are logic
        return sel;
    endfunction

endpackage

// ==== exec_pkg.sv ====
package exec_pkg;

    localparam int nr_regs        = 8;         // architectural registers
    localparam int reg_addr_width = 3;         // enough for nr_regs
    localparam int nr_lanes       = 2;         // execution lanes sharing one write port

    typedef logic [$clog2(nr_lanes)-1:0] lane_id_t;   // names lane 0 or lane 1

    // register form, second operand from rs2
    typedef struct packed {
        alu_pkg::alu_op_t          cmd;        // bits 15..12
        logic                      imm;        // bit 11, clear here
        logic [reg_addr_width-1:0] rd;         // bits 10..8
        logic [reg_addr_width-1:0] rs1;        // bits 7..5
        logic [reg_addr_width-1:0] rs2;        // bits 4..2
        logic [1:0]                pad;        // bits 1..0 ignored
    } instr_reg_t;

    // immediate form, second operand is imm5 zero-extended
    typedef struct packed {
        alu_pkg::alu_op_t          cmd;
        logic                      imm;        // set selects this view
        logic [reg_addr_width-1:0] rd;
        logic [reg_addr_width-1:0] rs1;
        logic [4:0]                imm5;       // bits 4..0
    } instr_imm_t;

    // the upper eleven bits line up in both views, so either can read cmd/rd/rs1
    typedef union packed {
        instr_reg_t reg_view;
        instr_imm_t imm_view;
    } instr_t;

endpackage

// ==== ripple_carry_adder.sv ====
`timescale 1ns/1ps

module ripple_carry_adder #(
    parameter int width = 16
) (
    input  logic [width-1:0] in1,
    input  logic [width-1:0] in2,
    input  logic             ci,               // carry into bit 0
    output logic [width-1:0] sum,
    output logic             co                // carry out of the top bit
);

    logic [width:0] carry;                     // carry chain, one per stage plus the input

    assign carry[0] = ci;

    for (genvar i = 0; i < width; i++) begin : fa
        logic half;                            // propagate term of this stage
        assign half         = in1[i] ^ in2[i];
        assign sum[i]       = half ^ carry[i];
        assign carry[i + 1] = (in1[i] & in2[i]) | (half & carry[i]);   // generate or propagate
    end

    assign co = carry[width];

endmodule

// ==== alu1.sv ====
`timescale 1ns/1ps

module alu1 (
    input  alu_pkg::alu_op_t cmd,
    input  alu_pkg::word_t   in1,
    input  alu_pkg::word_t   in2,
    output alu_pkg::word_t   out,
    output logic             co
);

    logic [alu_pkg::sel_width-1:0] sel;        // decoded selector bits
    alu_pkg::word_t                adder_in2;  // gated / inverted second operand
    alu_pkg::word_t                adder_sum;
    logic                          adder_co;
    alu_pkg::word_t                logic_out;  // result of the and/or/xor/not block

    assign sel = alu_pkg::op_sel(cmd);

    // a - b done as a + ~b + 1, the +1 comes in through the carry
    // with both selector bits set the operand is all ones, giving dec and transfer2
    assign adder_in2 = ({alu_pkg::word_width{sel[0]}} & in2) |
                       ({alu_pkg::word_width{sel[1]}} & ~in2);

    ripple_carry_adder #(
        .width (alu_pkg::word_width)
    ) adder_i (
        .in1 (in1),
        .in2 (adder_in2),
        .ci  (cmd[0]),                         // odd commands add one
        .sum (adder_sum),
        .co  (adder_co)
    );

    always_comb begin
        case (sel[1:0])
            2'b00:   logic_out = in1 & in2;    // and
            2'b01:   logic_out = in1 | in2;    // or
            2'b10:   logic_out = in1 ^ in2;    // xor
            default: logic_out = ~in1;         // not
        endcase
    end

    assign out = sel[2] ? logic_out : adder_sum;
    assign co  = sel[2] ? 1'b0 : adder_co;     // logic commands leave no carry

    // codes 12..15 have no meaning, the selector would quietly alias them onto logic ops
    cmd_in_range: assert final ($isunknown(cmd) || cmd <= alu_pkg::op_not)
        else $error("alu1 got undefined command %0d", cmd);

endmodule

// ==== reg_file.sv ====
`timescale 1ns/1ps

module reg_file (
    input  logic                                clk,
    input  logic                                rst_n,
    input  logic [exec_pkg::reg_addr_width-1:0] rd_addr_a0,   // lane 0 rs1
    input  logic [exec_pkg::reg_addr_width-1:0] rd_addr_b0,   // lane 0 rs2
    input  logic [exec_pkg::reg_addr_width-1:0] rd_addr_a1,   // lane 1 rs1
    input  logic [exec_pkg::reg_addr_width-1:0] rd_addr_b1,   // lane 1 rs2
    output alu_pkg::word_t                      rd_data_a0,
    output alu_pkg::word_t                      rd_data_b0,
    output alu_pkg::word_t                      rd_data_a1,
    output alu_pkg::word_t                      rd_data_b1,
    input  logic [exec_pkg::reg_addr_width-1:0] dbg_addr,
    output alu_pkg::word_t                      dbg_data,
    output logic                                dbg_co,
    input  logic                                we,
    input  logic [exec_pkg::reg_addr_width-1:0] wr_addr,
    input  alu_pkg::word_t                      wr_data,
    input  logic                                wr_co
);

    alu_pkg::word_t             regs [exec_pkg::nr_regs];   // data words
    logic [exec_pkg::nr_regs-1:0] carry;                    // carry that produced each word

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < exec_pkg::nr_regs; i++) begin
                regs[i] <= '0;
            end
            carry <= '0;
        end else if (we) begin
            regs[wr_addr]  <= wr_data;
            carry[wr_addr] <= wr_co;
        end
    end

    // all reads are asynchronous, a write shows up after the edge
    assign rd_data_a0 = regs[rd_addr_a0];
    assign rd_data_b0 = regs[rd_addr_b0];
    assign rd_data_a1 = regs[rd_addr_a1];
    assign rd_data_b1 = regs[rd_addr_b1];
    assign dbg_data   = regs[dbg_addr];
    assign dbg_co     = carry[dbg_addr];

endmodule

// ==== wb_arbiter.sv ====
`timescale 1ns/1ps

module wb_arbiter (
    input  logic                                clk,
    input  logic                                rst_n,
    input  logic                                req_0,
    input  logic                                req_1,
    input  logic [exec_pkg::reg_addr_width-1:0] rd_0,
    input  alu_pkg::word_t                      data_0,
    input  logic                                co_0,
    input  logic [exec_pkg::reg_addr_width-1:0] rd_1,
    input  alu_pkg::word_t                      data_1,
    input  logic                                co_1,
    output logic                                gnt_0,
    output logic                                gnt_1,
    output logic                                we,
    output logic [exec_pkg::reg_addr_width-1:0] wr_addr,
    output alu_pkg::word_t                      wr_data,
    output logic                                wr_co
);

    exec_pkg::lane_id_t prio;                  // lane that wins a tie

    // lone request always wins, a tie goes to prio
    assign gnt_0 = req_0 & (~req_1 | (prio == exec_pkg::lane_id_t'(0)));
    assign gnt_1 = req_1 & (~req_0 | (prio == exec_pkg::lane_id_t'(1)));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            prio <= exec_pkg::lane_id_t'(0);
        end else if (gnt_0) begin
            prio <= exec_pkg::lane_id_t'(1);   // lane 0 served, lane 1 next
        end else if (gnt_1) begin
            prio <= exec_pkg::lane_id_t'(0);
        end
    end

    // write port follows the granted lane
    assign we      = gnt_0 | gnt_1;
    assign wr_addr = gnt_1 ? rd_1 : rd_0;
    assign wr_data = gnt_1 ? data_1 : data_0;
    assign wr_co   = gnt_1 ? co_1 : co_0;

    // a lane that loses a tie keeps asking and wins on the next edge
    lose_then_win_0: assert property (@(posedge clk) disable iff (!rst_n)
        req_0 && !gnt_0 |=> gnt_0);
    lose_then_win_1: assert property (@(posedge clk) disable iff (!rst_n)
        req_1 && !gnt_1 |=> gnt_1);

endmodule

// ==== exec_lane.sv ====
`timescale 1ns/1ps

module exec_lane (
    input  logic                                clk,
    input  logic                                rst_n,
    input  logic                                issue,      // one-cycle strobe
    input  exec_pkg::instr_t                    instr,
    output logic                                busy,       // high from issue until write-back
    output logic [exec_pkg::reg_addr_width-1:0] rs1_addr,
    output logic [exec_pkg::reg_addr_width-1:0] rs2_addr,
    input  alu_pkg::word_t                      rs1_data,
    input  alu_pkg::word_t                      rs2_data,
    output logic                                wb_req,
    input  logic                                wb_gnt,
    output logic [exec_pkg::reg_addr_width-1:0] wb_rd,
    output alu_pkg::word_t                      wb_data,
    output logic                                wb_co
);

    exec_pkg::instr_t instr_q;                 // instruction held for the whole operation
    alu_pkg::word_t   alu_in2;
    alu_pkg::word_t   alu_out;
    logic             alu_co;
    logic             executing;               // first busy cycle, operands being read

    assign executing = busy & ~wb_req;

    always_ff @(posedge clk) begin
        if (issue && !busy) begin
            instr_q <= instr;
        end
    end

    assign rs1_addr = instr_q.reg_view.rs1;
    assign rs2_addr = instr_q.reg_view.rs2;
    assign wb_rd    = instr_q.reg_view.rd;

    // imm flag picks which view of the word supplies in2
    assign alu_in2 = instr_q.imm_view.imm ? alu_pkg::word_t'(instr_q.imm_view.imm5) : rs2_data;

    alu1 alu_i (
        .cmd (instr_q.reg_view.cmd),
        .in1 (rs1_data),
        .in2 (alu_in2),
        .out (alu_out),
        .co  (alu_co)
    );

    // idle -> executing -> waiting for grant -> idle, encoded in busy and wb_req
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy   <= 1'b0;
            wb_req <= 1'b0;
        end else if (!busy) begin
            busy <= issue;
        end else if (!wb_req) begin
            wb_req <= 1'b1;                    // result registered this edge
        end else if (wb_gnt) begin
            busy   <= 1'b0;                    // register file written this edge
            wb_req <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (executing) begin
            wb_data <= alu_out;
            wb_co   <= alu_co;
        end
    end

    no_issue_busy: assert property (@(posedge clk) disable iff (!rst_n) issue |-> !busy);
    hold_until_gnt: assert property (@(posedge clk) disable iff (!rst_n)
        wb_req && !wb_gnt |=> wb_req && $stable(wb_data) && $stable(wb_co) && $stable(wb_rd));

endmodule

// ==== alu_cluster.sv ====
`timescale 1ns/1ps

module alu_cluster (
    input  logic                                clk,
    input  logic                                rst_n,
    input  logic                                issue_0,
    input  exec_pkg::instr_t                    instr_0,
    output logic                                busy_0,
    input  logic                                issue_1,
    input  exec_pkg::instr_t                    instr_1,
    output logic                                busy_1,
    input  logic [exec_pkg::reg_addr_width-1:0] dbg_addr,
    output alu_pkg::word_t                      dbg_data,
    output logic                                dbg_co
);

    logic [exec_pkg::reg_addr_width-1:0] rs1_addr_0, rs2_addr_0, rs1_addr_1, rs2_addr_1;
    alu_pkg::word_t                      rs1_data_0, rs2_data_0, rs1_data_1, rs2_data_1;
    logic                                wb_req_0, wb_gnt_0, wb_co_0;    // lane 0 write-back
    logic                                wb_req_1, wb_gnt_1, wb_co_1;    // lane 1 write-back
    logic [exec_pkg::reg_addr_width-1:0] wb_rd_0, wb_rd_1;
    alu_pkg::word_t                      wb_data_0, wb_data_1;
    logic                                we, wr_co;                      // shared write port
    logic [exec_pkg::reg_addr_width-1:0] wr_addr;
    alu_pkg::word_t                      wr_data;

    exec_lane lane_0_i (
        .clk (clk), .rst_n (rst_n), .issue (issue_0), .instr (instr_0), .busy (busy_0),
        .rs1_addr (rs1_addr_0), .rs2_addr (rs2_addr_0),
        .rs1_data (rs1_data_0), .rs2_data (rs2_data_0),
        .wb_req (wb_req_0), .wb_gnt (wb_gnt_0),
        .wb_rd (wb_rd_0), .wb_data (wb_data_0), .wb_co (wb_co_0)
    );

    exec_lane lane_1_i (
        .clk (clk), .rst_n (rst_n), .issue (issue_1), .instr (instr_1), .busy (busy_1),
        .rs1_addr (rs1_addr_1), .rs2_addr (rs2_addr_1),
        .rs1_data (rs1_data_1), .rs2_data (rs2_data_1),
        .wb_req (wb_req_1), .wb_gnt (wb_gnt_1),
        .wb_rd (wb_rd_1), .wb_data (wb_data_1), .wb_co (wb_co_1)
    );

    wb_arbiter arb_i (
        .clk (clk), .rst_n (rst_n), .req_0 (wb_req_0), .req_1 (wb_req_1),
        .rd_0 (wb_rd_0), .data_0 (wb_data_0), .co_0 (wb_co_0),
        .rd_1 (wb_rd_1), .data_1 (wb_data_1), .co_1 (wb_co_1),
        .gnt_0 (wb_gnt_0), .gnt_1 (wb_gnt_1),
        .we (we), .wr_addr (wr_addr), .wr_data (wr_data), .wr_co (wr_co)
    );

    reg_file rf_i (
        .clk (clk), .rst_n (rst_n),
        .rd_addr_a0 (rs1_addr_0), .rd_addr_b0 (rs2_addr_0),
        .rd_addr_a1 (rs1_addr_1), .rd_addr_b1 (rs2_addr_1),
        .rd_data_a0 (rs1_data_0), .rd_data_b0 (rs2_data_0),
        .rd_data_a1 (rs1_data_1), .rd_data_b1 (rs2_data_1),
        .dbg_addr (dbg_addr), .dbg_data (dbg_data), .dbg_co (dbg_co),
        .we (we), .wr_addr (wr_addr), .wr_data (wr_data), .wr_co (wr_co)
    );

endmodule

// ==== tb_alu_cluster.sv ====
`timescale 1ns/1ps

module tb_alu_cluster;

    logic                                clk;
    logic                                rst_n;
    logic                                issue_0;
    logic                                issue_1;
    exec_pkg::instr_t                    instr_0;
    exec_pkg::instr_t                    instr_1;
    logic                                busy_0;
    logic                                busy_1;
    logic [exec_pkg::reg_addr_width-1:0] dbg_addr;
    alu_pkg::word_t                      dbg_data;
    logic                                dbg_co;

    int          fd;                           // trace file handle
    int          err_count = 0;                // mismatches seen so far
    int          n_pass = 0;
    int          n_fail = 0;
    bit          aborted = 0;                  // timeout or broken trace
    logic [15:0] lfsr_state = 16'd25113;

    alu_cluster dut_i (
        .clk (clk), .rst_n (rst_n),
        .issue_0 (issue_0), .instr_0 (instr_0), .busy_0 (busy_0),
        .issue_1 (issue_1), .instr_1 (instr_1), .busy_1 (busy_1),
        .dbg_addr (dbg_addr), .dbg_data (dbg_data), .dbg_co (dbg_co)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;                // 40 ns period
    end

    // taps 16, 14, 13, 11
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        logic fb;
        fb = s[15] ^ s[13] ^ s[12] ^ s[10];
        return {s[14:0], fb};
    endfunction

    task automatic pick_gap(output int gap);
        logic [1:0] bits;
        lfsr_state = lfsr_next(lfsr_state);
        bits[0]    = lfsr_state[0];            // one step per bit taken
        lfsr_state = lfsr_next(lfsr_state);
        bits[1]    = lfsr_state[0];
        gap        = bits;
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #2;                                    // inputs change just after the edge
    endtask

    task automatic check_word(input string name, input alu_pkg::word_t exp,
                              input alu_pkg::word_t act);
        if (act !== exp) begin
            $display("ERR %s expected %h got %h", name, exp, act);
            err_count++;
        end
    endtask

    task automatic check_carry(input string name, input bit exp, input bit act);
        if (act !== exp) begin
            $display("ERR %s expected %h got %h", name, exp, act);
            err_count++;
        end
    endtask

    task automatic check_level(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("ERR %s expected %h got %h", name, exp, act);
            err_count++;
        end
    endtask

    task automatic report_test(input string what, input int errs_before);
        if (err_count == errs_before) begin
            n_pass++;
            $display("%s: ok", what);
        end else begin
            n_fail++;
            $display("%s: mismatch", what);
        end
    endtask

    // debug port read, sampled mid-cycle where the mux has settled
    task automatic check_result(input exec_pkg::instr_t instr, input alu_pkg::word_t exp_val,
                                input bit exp_co);
        int rd;
        rd       = instr.reg_view.rd;
        dbg_addr = instr.reg_view.rd;
        @(negedge clk);
        check_word($sformatf("dbg_data[r%0d]", rd), exp_val, dbg_data);
        check_carry($sformatf("dbg_co[r%0d]", rd), exp_co, dbg_co);
        next_cycle();
    endtask

    task automatic check_reset();
        int errs_before;
        errs_before = err_count;
        check_level("busy_0", 1'b0, busy_0);
        check_level("busy_1", 1'b0, busy_1);
        for (int a = 0; a < exec_pkg::nr_regs; a++) begin
            dbg_addr = a[exec_pkg::reg_addr_width-1:0];
            @(negedge clk);
            check_word($sformatf("dbg_data[r%0d]", a), '0, dbg_data);
            check_carry($sformatf("dbg_co[r%0d]", a), 1'b0, dbg_co);
            next_cycle();
        end
        report_test("reset state", errs_before);
    endtask

    task automatic drive_issue(input int lane, input exec_pkg::instr_t instr);
        if (lane == 0) begin
            issue_0 = 1'b1;
            instr_0 = instr;
        end else begin
            issue_1 = 1'b1;
            instr_1 = instr;
        end
    endtask

    // one strobe cycle, then back to idle inputs
    task automatic end_issue();
        next_cycle();
        issue_0 = 1'b0;
        issue_1 = 1'b0;
    endtask

    task automatic wait_idle();
        int cycles;
        cycles = 0;
        while ((busy_0 || busy_1) && cycles < 50) begin
            next_cycle();
            cycles++;
        end
        if (busy_0) begin
            $display("lane 0 never finished");
            aborted = 1;
        end
        if (busy_1) begin
            $display("lane 1 never finished");
            aborted = 1;
        end
    endtask

    // skips comment and blank lines, found stays low at end of file
    task automatic read_entry(output bit found, output int lane, output exec_pkg::instr_t instr,
                              output int par, output alu_pkg::word_t val, output bit co);
        string       line;
        int          code;
        logic [15:0] ih;
        logic [15:0] vh;
        int          cv;
        found = 0;
        while (!found && !$feof(fd)) begin
            code = $fgets(line, fd);
            if (code > 0 && line.len() > 0 && line[0] != "#") begin
                if ($sscanf(line, "%d %h %d %h %d", lane, ih, par, vh, cv) == 5) begin
                    found = 1;
                    instr = ih;
                    val   = vh;
                    co    = (cv != 0);
                end
            end
        end
    endtask

    initial begin
        bit               found_a, found_b;
        int               lane_a, lane_b, par_a, par_b;
        int               gap, idx, errs_before;
        exec_pkg::instr_t instr_a, instr_b;
        alu_pkg::word_t   val_a, val_b;
        bit               co_a, co_b;

        rst_n    = 1'b0;
        issue_0  = 1'b0;
        issue_1  = 1'b0;
        instr_0  = '0;
        instr_1  = '0;
        dbg_addr = '0;
        idx      = 0;
        repeat (4) @(posedge clk);             // reset held for four cycles
        #2;
        rst_n = 1'b1;

        check_reset();

        fd = $fopen("alu_cluster_trace.txt", "r");
        if (fd == 0) begin
            $display("cannot open alu_cluster_trace.txt");
            aborted = 1;
        end

        while (!aborted) begin
            read_entry(found_a, lane_a, instr_a, par_a, val_a, co_a);
            if (!found_a) break;
            if (par_a != 0) begin
                read_entry(found_b, lane_b, instr_b, par_b, val_b, co_b);
                if (!found_b || lane_b == lane_a) begin
                    $display("trace has a parallel pair without a second lane");
                    aborted = 1;
                    break;
                end
                drive_issue(lane_a, instr_a);  // same edge for both lanes
                drive_issue(lane_b, instr_b);
                end_issue();
                wait_idle();
                if (aborted) break;
                idx++;
                errs_before = err_count;
                check_result(instr_a, val_a, co_a);
                report_test($sformatf("trace %0d lane %0d instr %h", idx, lane_a, instr_a),
                            errs_before);
                idx++;
                errs_before = err_count;
                check_result(instr_b, val_b, co_b);
                report_test($sformatf("trace %0d lane %0d instr %h", idx, lane_b, instr_b),
                            errs_before);
            end else begin
                pick_gap(gap);
                repeat (gap) next_cycle();     // idle cycles between issues
                drive_issue(lane_a, instr_a);
                end_issue();
                wait_idle();
                if (aborted) break;
                idx++;
                errs_before = err_count;
                check_result(instr_a, val_a, co_a);
                report_test($sformatf("trace %0d lane %0d instr %h", idx, lane_a, instr_a),
                            errs_before);
            end
        end

        if (fd != 0) $fclose(fd);
        $display("tests run %0d, ok %0d, mismatched %0d", n_pass + n_fail, n_pass, n_fail);
        if (n_fail == 0 && !aborted) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

// ==== alu_cluster_trace.txt ====
# lane(dec) instr(hex) parallel_with_next(0/1) expected_rd_value(hex) expected_carry(0/1)
# instr: cmd[15:12] imm[11] rd[10:8] rs1[7:5] then rs2[4:2] or imm5[4:0]
0 991F 0 001F 0
1 9A05 0 0005 0
0 2328 0 0024 0
1 B400 0 FFFF 0
0 1580 0 0000 1
1 2584 0 001E 1
0 3688 0 0005 1
1 4628 0 0019 1
0 5744 0 FFE6 0
1 5728 0 001A 1
0 6340 0 0004 1
1 6500 0 FFFF 0
0 0680 0 FFFF 0
1 7620 0 001F 1
0 8F8A 0 000A 0
1 AB89 0 FFF6 0
0 A389 0 FFFA 0
0 2190 1 FFFE 1
1 5210 0 0001 0
1 1520 1 FFFF 0
0 AE5F 0 001E 0

// ==== filelist.f ====
alu_pkg.sv
exec_pkg.sv
ripple_carry_adder.sv
alu1.sv
reg_file.sv
wb_arbiter.sv
exec_lane.sv
alu_cluster.sv
tb_alu_cluster.sv
